//--- list.f
buf_pkg.sv
ram_tp.sv
fifo.sv
fifo_wm_regs.sv
stream_buf_top.sv
stream_buf_chk.sv
tb_stream_buf.sv

//--- Makefile
TOP = tb_stream_buf

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_stream_buf.sv
// Testbench for the word buffer. Random words go through the FIFO against a queue
// model, and a per-cycle compare checks status, flags, read data and register read-back.

`timescale 1ns/1ps

module tb_stream_buf;

    import buf_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 16;
    localparam int RAND_CYCLES = 400;
    localparam int TEST_CYCLES = RST_CYCLES + 10 + 30 + 30 + 80 + RAND_CYCLES + 10;
    localparam int MARGIN      = 200;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  wr_en_i;
    logic [DATA_W-1:0]     wr_data_i;
    logic                  rd_en_i;
    logic [DATA_W-1:0]     rd_data_o;
    wr_status_t            wr_status_o;
    rd_status_t            rd_status_o;
    wm_flags_t             wm_flags_o;
    logic                  overflow_o;
    logic                  cfg_we_i;
    logic [REG_ADDR_W-1:0] cfg_addr_i;
    logic [CNT_W-1:0]      cfg_wdata_i;
    logic [CNT_W-1:0]      cfg_rdata_o;

    logic [DATA_W-1:0]     model_q[$];
    logic [DATA_W-1:0]     exp_rd_data;
    logic [CNT_W-1:0]      m_af_lvl;
    logic [CNT_W-1:0]      m_ae_lvl;
    logic                  m_ovf;
    int                    err_cnt;
    int                    check_cnt;
    int                    test_err_start;

    stream_buf_top u_stream_buf_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Watchdog timed out after %0d cycles, the tests did not finish.",
                 TEST_CYCLES + MARGIN);
        $display("Result: FAILED");
        $finish;
    end

    // Expected status and flags for a given stored count and pair of levels.
    function automatic void ref_status(input int cnt, input logic [CNT_W-1:0] af_lvl,
                                       input logic [CNT_W-1:0] ae_lvl,
                                       output wr_status_t ws, output rd_status_t rs,
                                       output wm_flags_t wf);
        ws.free         = CNT_W'(FIFO_DEPTH - cnt);
        ws.full         = (cnt == FIFO_DEPTH);
        ws.last         = (cnt == FIFO_DEPTH - 1);
        rs.avail        = CNT_W'(cnt);
        rs.empty        = (cnt == 0);
        rs.last         = (cnt == 1);
        wf.almost_full  = ((FIFO_DEPTH - cnt) <= int'(af_lvl));
        wf.almost_empty = (cnt <= int'(ae_lvl));
    endfunction

    task automatic check(input string what, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Outputs are compared at the falling edge, where they are stable.
    always @(negedge clk_i) begin : compare_proc
        wr_status_t       ws;
        rd_status_t       rs;
        wm_flags_t        wf;
        logic [CNT_W-1:0] exp_rdata;
        logic             wr_acc;
        logic             rd_acc;
        if (!rst_n_i) begin
            model_q.delete();
            exp_rd_data = '0;
            m_af_lvl    = AF_LVL_RST;
            m_ae_lvl    = AE_LVL_RST;
            m_ovf       = 1'b0;
        end else begin
            ref_status(model_q.size(), m_af_lvl, m_ae_lvl, ws, rs, wf);
            case (cfg_addr_i)
                REG_AF_LVL: exp_rdata = m_af_lvl;
                REG_AE_LVL: exp_rdata = m_ae_lvl;
                REG_AVAIL:  exp_rdata = rs.avail;
                default:    exp_rdata = CNT_W'(m_ovf);
            endcase
            check("wr_status", DATA_W'(wr_status_o), DATA_W'(ws));
            check("rd_status", DATA_W'(rd_status_o), DATA_W'(rs));
            check("wm_flags", DATA_W'(wm_flags_o), DATA_W'(wf));
            check("overflow", DATA_W'(overflow_o), DATA_W'(m_ovf));
            check("cfg_rdata", DATA_W'(cfg_rdata_o), DATA_W'(exp_rdata));
            check("rd_data", rd_data_o, exp_rd_data);
            // Predict the next rising edge from the inputs it will sample.
            wr_acc = wr_en_i && (model_q.size() < FIFO_DEPTH);
            rd_acc = rd_en_i && (model_q.size() > 0);
            if (rd_acc) exp_rd_data = model_q.pop_front();
            if (wr_acc) model_q.push_back(wr_data_i);
            if (wr_en_i && !wr_acc) begin
                m_ovf = 1'b1;
            end else if (cfg_we_i && cfg_addr_i == REG_OVF) begin
                m_ovf = 1'b0;
            end
            if (cfg_we_i && cfg_addr_i == REG_AF_LVL) m_af_lvl = cfg_wdata_i;
            if (cfg_we_i && cfg_addr_i == REG_AE_LVL) m_ae_lvl = cfg_wdata_i;
        end
    end

    task automatic drive(input logic we, input logic [DATA_W-1:0] wdata, input logic re);
        @(posedge clk_i);
        wr_en_i   <= we;
        wr_data_i <= wdata;
        rd_en_i   <= re;
        cfg_we_i  <= 1'b0;
    endtask

    task automatic settle();
        drive(1'b0, '0, 1'b0);
        @(negedge clk_i);
    endtask

    task automatic cfg_write(input logic [REG_ADDR_W-1:0] addr, input logic [CNT_W-1:0] data);
        @(posedge clk_i);
        wr_en_i     <= 1'b0;
        rd_en_i     <= 1'b0;
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
    endtask

    task automatic cfg_read(input logic [REG_ADDR_W-1:0] addr, input logic [CNT_W-1:0] exp);
        @(posedge clk_i);
        wr_en_i    <= 1'b0;
        rd_en_i    <= 1'b0;
        cfg_we_i   <= 1'b0;
        cfg_addr_i <= addr;
        @(negedge clk_i);
        check("register read-back", DATA_W'(cfg_rdata_o), DATA_W'(exp));
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d (%s): %0d errors", num, name, err_cnt - test_err_start);
        test_err_start = err_cnt;
    endtask

    initial begin
        logic [DATA_W-1:0] held;
        void'($urandom(99));
        err_cnt        = 0;
        check_cnt      = 0;
        test_err_start = 0;
        rst_n_i        = 1'b0;
        wr_en_i        = 1'b0;
        wr_data_i      = '0;
        rd_en_i        = 1'b0;
        cfg_we_i       = 1'b0;
        cfg_addr_i     = '0;
        cfg_wdata_i    = '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        @(negedge clk_i);
        check("empty after reset", DATA_W'(rd_status_o.empty), DATA_W'(1'b1));
        check("rd last after reset", DATA_W'(rd_status_o.last), DATA_W'(1'b0));
        check("avail after reset", DATA_W'(rd_status_o.avail), DATA_W'(0));
        check("free after reset", DATA_W'(wr_status_o.free), DATA_W'(FIFO_DEPTH));
        check("almost_empty after reset", DATA_W'(wm_flags_o.almost_empty), DATA_W'(1'b1));
        check("almost_full after reset", DATA_W'(wm_flags_o.almost_full), DATA_W'(1'b0));
        check("overflow after reset", DATA_W'(overflow_o), DATA_W'(1'b0));
        cfg_read(REG_AF_LVL, CNT_W'(2));
        cfg_read(REG_AE_LVL, CNT_W'(2));
        report_test(1, "reset state");

        for (int i = 0; i < FIFO_DEPTH - 1; i++) drive(1'b1, $urandom, 1'b0);
        settle();
        check("wr last at 15 words", DATA_W'(wr_status_o.last), DATA_W'(1'b1));
        held = $urandom; // The last word stored is the last one drained.
        drive(1'b1, held, 1'b0);
        settle();
        check("full at 16 words", DATA_W'(wr_status_o.full), DATA_W'(1'b1));
        drive(1'b1, $urandom, 1'b0); // This write finds the FIFO full.
        settle();
        check("overflow after dropped write", DATA_W'(overflow_o), DATA_W'(1'b1));
        check("avail after dropped write", DATA_W'(rd_status_o.avail), DATA_W'(FIFO_DEPTH));
        cfg_write(REG_OVF, '0);
        settle();
        cfg_read(REG_OVF, '0);
        report_test(2, "fill and overflow");

        for (int i = 0; i < FIFO_DEPTH - 1; i++) drive(1'b0, '0, 1'b1);
        settle();
        check("rd last at 1 word", DATA_W'(rd_status_o.last), DATA_W'(1'b1));
        drive(1'b0, '0, 1'b1);
        settle();
        drive(1'b0, '0, 1'b1);
        settle();
        check("rd_data after read on empty", rd_data_o, held);
        check("avail after read on empty", DATA_W'(rd_status_o.avail), DATA_W'(0));
        report_test(3, "drain and read on empty");

        cfg_write(REG_AF_LVL, CNT_W'(5));
        cfg_write(REG_AE_LVL, CNT_W'(12));
        cfg_read(REG_AF_LVL, CNT_W'(5));
        cfg_read(REG_AE_LVL, CNT_W'(12));
        cfg_read(REG_AVAIL, '0);
        for (int c = 1; c <= FIFO_DEPTH; c++) begin
            drive(1'b1, $urandom, 1'b0);
            settle();
            check("REG_AVAIL while filling", DATA_W'(cfg_rdata_o), DATA_W'(c));
        end
        for (int c = FIFO_DEPTH - 1; c >= 0; c--) begin
            drive(1'b0, '0, 1'b1);
            settle();
            check("REG_AVAIL while draining", DATA_W'(cfg_rdata_o), DATA_W'(c));
        end
        report_test(4, "watermark levels");

        for (int i = 0; i < RAND_CYCLES; i++) begin
            // Write-heavy and read-heavy phases take the FIFO to both ends.
            if ((i / 50) % 2 == 0) begin
                drive(($urandom % 4) != 0, $urandom, ($urandom % 4) == 0);
            end else begin
                drive(($urandom % 4) == 0, $urandom, ($urandom % 4) != 0);
            end
        end
        settle();
        report_test(5, "random traffic");

        repeat (2) @(posedge clk_i);
        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- stream_buf_chk.sv
// Concurrent assertions on the status ports of the word buffer.
// Bound into stream_buf_top by the bind statement at the end of this file.

`timescale 1ns/1ps

module stream_buf_chk (
    input logic                clk_i,
    input logic                rst_n_i,
    input buf_pkg::wr_status_t wr_status_i,
    input buf_pkg::rd_status_t rd_status_i
);

    import buf_pkg::*;

    full_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wr_status_i.full && rd_status_i.empty))
        else $error("full and empty are high together");

    // Free and stored words always add up to the depth.
    count_sum: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (int'(wr_status_i.free) + int'(rd_status_i.avail)) == FIFO_DEPTH)
        else $error("free plus avail differs from the FIFO depth");

    no_rise_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_status_i.full |=> (rd_status_i.avail <= $past(rd_status_i.avail)))
        else $error("avail rose while the FIFO was full");

endmodule

bind stream_buf_top stream_buf_chk u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_status_i (wr_status_o),
    .rd_status_i (rd_status_o)
);

//--- stream_buf_top.sv
// Top level of the word buffer: the FIFO and its watermark register block.
// Status structs go both to the ports and to the register block.

`timescale 1ns/1ps

module stream_buf_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    input  logic                           wr_en_i,
    input  logic [buf_pkg::DATA_W-1:0]     wr_data_i,
    input  logic                           rd_en_i,
    output logic [buf_pkg::DATA_W-1:0]     rd_data_o,

    output buf_pkg::wr_status_t            wr_status_o,
    output buf_pkg::rd_status_t            rd_status_o,
    output buf_pkg::wm_flags_t             wm_flags_o,
    output logic                           overflow_o,

    input  logic                           cfg_we_i,
    input  logic [buf_pkg::REG_ADDR_W-1:0] cfg_addr_i,
    input  logic [buf_pkg::CNT_W-1:0]      cfg_wdata_i,
    output logic [buf_pkg::CNT_W-1:0]      cfg_rdata_o
);

    import buf_pkg::*;

    fifo #(
        .WIDTH (DATA_W),
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_en_i     (wr_en_i),
        .wr_data_i   (wr_data_i),
        .wr_status_o (wr_status_o),
        .rd_en_i     (rd_en_i),
        .rd_data_o   (rd_data_o),
        .rd_status_o (rd_status_o)
    );

    // The register block sees the raw write strobe to catch dropped writes.
    fifo_wm_regs u_wm_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .wr_en_i     (wr_en_i),
        .wr_status_i (wr_status_o),
        .rd_status_i (rd_status_o),
        .wm_flags_o  (wm_flags_o),
        .overflow_o  (overflow_o)
    );

endmodule

//--- fifo_wm_regs.sv
// Watermark register block beside the FIFO. It holds the almost-full and
// almost-empty levels and a sticky overflow bit, and reads back levels and count.
// Writes take effect in the next cycle; the read mux is combinational.

`timescale 1ns/1ps

module fifo_wm_regs (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    input  logic                           cfg_we_i,
    input  logic [buf_pkg::REG_ADDR_W-1:0] cfg_addr_i,
    input  logic [buf_pkg::CNT_W-1:0]      cfg_wdata_i,
    output logic [buf_pkg::CNT_W-1:0]      cfg_rdata_o,

    input  logic                           wr_en_i,
    input  buf_pkg::wr_status_t            wr_status_i,
    input  buf_pkg::rd_status_t            rd_status_i,
    output buf_pkg::wm_flags_t             wm_flags_o,
    output logic                           overflow_o
);

    import buf_pkg::*;

    logic [CNT_W-1:0] af_lvl;
    logic [CNT_W-1:0] ae_lvl;
    logic             ovf;
    logic             ovf_set;
    logic             ovf_clr;

    // A write strobe while full is a dropped word.
    assign ovf_set = wr_en_i & wr_status_i.full;
    assign ovf_clr = cfg_we_i & (cfg_addr_i == REG_OVF);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            af_lvl <= AF_LVL_RST;
            ae_lvl <= AE_LVL_RST;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                REG_AF_LVL: af_lvl <= cfg_wdata_i;
                REG_AE_LVL: ae_lvl <= cfg_wdata_i;
                default: ; // Count is read only, overflow is handled below.
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ovf <= 1'b0;
        end else if (ovf_set) begin
            ovf <= 1'b1; // Set wins over a clear in the same cycle.
        end else if (ovf_clr) begin
            ovf <= 1'b0;
        end
    end

    assign overflow_o = ovf;

    assign wm_flags_o.almost_full  = (wr_status_i.free <= af_lvl);
    assign wm_flags_o.almost_empty = (rd_status_i.avail <= ae_lvl);

    always_comb begin
        case (cfg_addr_i)
            REG_AF_LVL: cfg_rdata_o = af_lvl;
            REG_AE_LVL: cfg_rdata_o = ae_lvl;
            REG_AVAIL:  cfg_rdata_o = rd_status_i.avail;
            default:    cfg_rdata_o = {{(CNT_W - 1){1'b0}}, ovf};
        endcase
    end

endmodule

//--- fifo.sv
// Synchronous FIFO built on ram_tp with pointers one bit wider than the address.
// Write and read status are combinational on the pointers; read data comes one
// cycle after an accepted read.

`timescale 1ns/1ps

module fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               wr_en_i,
    input  logic [WIDTH-1:0]   wr_data_i,
    output buf_pkg::wr_status_t wr_status_o,

    input  logic               rd_en_i,
    output logic [WIDTH-1:0]   rd_data_o,
    output buf_pkg::rd_status_t rd_status_o
);

    import buf_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] used_cnt;
    logic [AW:0] free_cnt;
    logic        full;
    logic        empty;
    logic        wr_accept;
    logic        rd_accept;

    // The extra top bit tells a full buffer from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});

    assign used_cnt = wr_ptr - rd_ptr; // Wraps correctly modulo 2*DEPTH.
    assign free_cnt = FULL_CNT - used_cnt;

    assign wr_accept = wr_en_i & ~full;
    assign rd_accept = rd_en_i & ~empty;

    assign wr_status_o.last = (free_cnt == (AW + 1)'(1));
    assign wr_status_o.full = full;
    assign wr_status_o.free = CNT_W'(free_cnt);

    assign rd_status_o.last  = (used_cnt == (AW + 1)'(1));
    assign rd_status_o.empty = empty;
    assign rd_status_o.avail = CNT_W'(used_cnt);

    ram_tp #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) u_ram (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_accept),
        .wr_addr_i (wr_ptr[AW-1:0]),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_accept),
        .rd_addr_i (rd_ptr[AW-1:0]),
        .rd_data_o (rd_data_o)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- ram_tp.sv
// Two-port RAM with one write port and a registered read port on a single clock.
// The read register loads only on rd_en_i and otherwise holds its last word.

`timescale 1ns/1ps

module ram_tp #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic [WIDTH-1:0]         wr_data_i,

    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output logic [WIDTH-1:0]         rd_data_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

//--- buf_pkg.sv
// Shared sizes, register map, status structs and reset levels for the word buffer.
// Modules import it inside their bodies and name its types with buf_pkg:: in port lists.

package buf_pkg;

    localparam int DATA_W     = 32;
    localparam int FIFO_DEPTH = 16;                     // Must stay a power of two.
    localparam int CNT_W      = $clog2(FIFO_DEPTH) + 1; // Counts run from 0 to FIFO_DEPTH.
    localparam int REG_ADDR_W = 2;

    // Register map of the watermark block.
    localparam logic [REG_ADDR_W-1:0] REG_AF_LVL = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_AE_LVL = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_AVAIL  = 2'd2; // Read only.
    localparam logic [REG_ADDR_W-1:0] REG_OVF    = 2'd3; // Any write clears the bit.

    localparam logic [CNT_W-1:0] AF_LVL_RST = CNT_W'(2);
    localparam logic [CNT_W-1:0] AE_LVL_RST = CNT_W'(2);

    typedef struct packed {
        logic             last;
        logic             full;
        logic [CNT_W-1:0] free;
    } wr_status_t;

    typedef struct packed {
        logic             last;
        logic             empty;
        logic [CNT_W-1:0] avail;
    } rd_status_t;

    typedef struct packed {
        logic almost_full;
        logic almost_empty;
    } wm_flags_t;

endpackage
